//--- rtl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // bridge command: op bit, remote address, write data.
  typedef logic [15:0] cmd_t;

  // one frame payload or read result.
  typedef logic [7:0] byte_t;

  // clock cycles per bit time.
  typedef logic [15:0] baud_div_t;

  // wishbone word address and data.
  typedef logic [1:0] wb_adr_t;
  typedef logic [15:0] wb_data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam wb_adr_t REG_BAUD = 2'd0;
  localparam wb_adr_t REG_CTRL = 2'd1;
  localparam wb_adr_t REG_CMD = 2'd2;
  localparam wb_adr_t REG_STATUS = 2'd3;

  // 115200 baud from a 50 MHz clock.
  localparam baud_div_t BAUD_DIV_RESET = 16'd434;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame and command layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // idle bit times between the two bytes of a write.
  localparam int GAP_BITS = 4;

  // 1 = write, 0 = read.
  localparam int CMD_WRITE_BIT = 15;

  // start, 8 data, parity, stop.
  localparam int FRAME_BITS = 11;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status register bits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int ST_BUSY = 0;
  localparam int ST_RD_VALID = 1;
  localparam int ST_PARITY_ERR = 2;
  localparam int ST_FRAME_ERR = 3;
  localparam int ST_CMD_DROP = 4;

  // read byte sits in the upper half of STATUS.
  localparam int ST_RD_DATA_LSB = 8;

endpackage

//--- rtl/uart_cfg_regs.sv
module uart_cfg_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  uart_cmd_pkg::wb_adr_t  wb_adr,
  input  uart_cmd_pkg::wb_data_t wb_dat_w,
  input  logic                   cmd_rdy,
  input  logic                   rx_valid,
  input  logic                   rx_parity_err,
  input  logic                   rx_frame_err,
  input  uart_cmd_pkg::byte_t    rx_data,
  output uart_cmd_pkg::wb_data_t wb_dat_r,
  output logic                   wb_ack,
  output uart_cmd_pkg::baud_div_t baud_div,
  output logic                   parity_odd,
  output uart_cmd_pkg::cmd_t     cmd,
  output logic                   cmd_vld
);

  uart_cmd_pkg::wb_data_t ctrl_q;
  uart_cmd_pkg::wb_data_t status_w;
  uart_cmd_pkg::wb_data_t rd_mux;
  uart_cmd_pkg::byte_t    rd_data_q;
  logic                   rd_valid_q;
  logic                   parity_err_q;
  logic                   frame_err_q;
  logic                   cmd_drop_q;
  logic                   busy;
  logic                   wb_acc;
  logic                   wb_wr;

  // one access per ack, with a gap cycle in between.
  assign wb_acc = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr = wb_acc & wb_we;

  // engine away from idle reads as busy.
  assign busy = ~cmd_rdy;
  assign parity_odd = ctrl_q[0];

  always_comb
  begin
    status_w = '0;
    status_w[uart_cmd_pkg::ST_BUSY] = busy;
    status_w[uart_cmd_pkg::ST_RD_VALID] = rd_valid_q;
    status_w[uart_cmd_pkg::ST_PARITY_ERR] = parity_err_q;
    status_w[uart_cmd_pkg::ST_FRAME_ERR] = frame_err_q;
    status_w[uart_cmd_pkg::ST_CMD_DROP] = cmd_drop_q;
    status_w[uart_cmd_pkg::ST_RD_DATA_LSB +: 8] = rd_data_q;
    case (wb_adr)
      uart_cmd_pkg::REG_BAUD: rd_mux = baud_div;
      uart_cmd_pkg::REG_CTRL: rd_mux = ctrl_q;
      uart_cmd_pkg::REG_CMD:  rd_mux = cmd;
      default:                rd_mux = status_w;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack <= 1'b0;
      baud_div <= uart_cmd_pkg::BAUD_DIV_RESET;
      ctrl_q <= '0;
      cmd <= '0;
      cmd_vld <= 1'b0;
      rd_data_q <= '0;
      rd_valid_q <= 1'b0;
      parity_err_q <= 1'b0;
      frame_err_q <= 1'b0;
      cmd_drop_q <= 1'b0;
    end
    else
    begin
      wb_ack <= wb_acc;
      cmd_vld <= 1'b0;
      if (wb_wr)
      begin
        case (wb_adr)
          uart_cmd_pkg::REG_BAUD: baud_div <= wb_dat_w;
          uart_cmd_pkg::REG_CTRL: ctrl_q <= wb_dat_w;
          uart_cmd_pkg::REG_CMD:
          begin
            cmd <= wb_dat_w;
            if (cmd_rdy)
              cmd_vld <= 1'b1;
            else
              cmd_drop_q <= 1'b1;
          end
          default:
          begin
            // write one to clear.
            if (wb_dat_w[uart_cmd_pkg::ST_RD_VALID])
              rd_valid_q <= 1'b0;
            if (wb_dat_w[uart_cmd_pkg::ST_PARITY_ERR])
              parity_err_q <= 1'b0;
            if (wb_dat_w[uart_cmd_pkg::ST_FRAME_ERR])
              frame_err_q <= 1'b0;
            if (wb_dat_w[uart_cmd_pkg::ST_CMD_DROP])
              cmd_drop_q <= 1'b0;
          end
        endcase
      end
      // a new reply wins over a clear in the same cycle.
      if (rx_valid)
      begin
        rd_data_q <= rx_data;
        rd_valid_q <= 1'b1;
        parity_err_q <= parity_err_q | rx_parity_err;
        frame_err_q <= frame_err_q | rx_frame_err;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wb_acc && !wb_we)
      wb_dat_r <= rd_mux;
  end

  a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_stb);

endmodule

//--- rtl/uart_tx_frame.sv
module uart_tx_frame (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::baud_div_t baud_div,
  input  logic                    parity_odd,
  input  logic                    tx_start,
  input  uart_cmd_pkg::byte_t     tx_data,
  output logic                    tx_busy,
  output logic                    tx_done,
  output logic                    tx
);

  logic [uart_cmd_pkg::FRAME_BITS-1:0] frame_q;
  uart_cmd_pkg::baud_div_t             baud_cnt;
  logic [3:0]                          bit_cnt;
  logic                                parity_bit;
  logic                                bit_end;
  logic                                last_bit;

  // even parity makes the ones count even, odd flips it.
  assign parity_bit = (^tx_data) ^ parity_odd;

  assign bit_end = tx_busy && (baud_cnt == baud_div - 16'd1);
  assign last_bit = (bit_cnt == 4'(uart_cmd_pkg::FRAME_BITS - 1));

  // done in the final cycle of the stop bit.
  assign tx_done = bit_end & last_bit;

  // line idles high because the shifter refills with ones.
  assign tx = frame_q[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shifter and bit timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_q <= '1;
      tx_busy <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (tx_start)
    begin
      // stop, parity, data lsb first, start.
      frame_q <= {1'b1, parity_bit, tx_data, 1'b0};
      tx_busy <= 1'b1;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      frame_q <= {1'b1, frame_q[uart_cmd_pkg::FRAME_BITS-1:1]};
      if (last_bit)
        tx_busy <= 1'b0;
      else
        bit_cnt <= bit_cnt + 4'd1;
    end
    else if (tx_busy)
    begin
      baud_cnt <= baud_cnt + 16'd1;
    end
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

//--- rtl/uart_rx_frame.sv
module uart_rx_frame (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::baud_div_t baud_div,
  input  logic                    parity_odd,
  input  logic                    rx_enable,
  input  logic                    rx,
  output uart_cmd_pkg::byte_t     rx_data,
  output logic                    rx_valid,
  output logic                    rx_parity_err,
  output logic                    rx_frame_err
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_t;

  rx_state_t               state_q;
  logic                    rx_s1;
  logic                    rx_s2;
  logic                    rx_prev;
  uart_cmd_pkg::baud_div_t baud_cnt;
  uart_cmd_pkg::baud_div_t half_div;
  logic [3:0]              bit_cnt;
  logic [9:0]              shift_q;
  logic [9:0]              shift_next;
  logic                    fall;

  assign half_div = baud_div >> 1;
  assign fall = rx_prev & ~rx_s2;

  // data lsb first, then parity, then stop ends up at the top.
  assign shift_next = {rx_s2, shift_q[9:1]};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input synchronizer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt <= '0;
      shift_q <= '0;
      rx_valid <= 1'b0;
      rx_data <= '0;
      rx_parity_err <= 1'b0;
      rx_frame_err <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      case (state_q)
        RX_IDLE:
        begin
          baud_cnt <= '0;
          if (rx_enable && fall)
            state_q <= RX_START;
        end
        RX_START:
        begin
          // a glitch shorter than half a bit is dropped.
          if (baud_cnt == half_div - 16'd1)
          begin
            baud_cnt <= '0;
            bit_cnt <= '0;
            state_q <= rx_s2 ? RX_IDLE : RX_BITS;
          end
          else
            baud_cnt <= baud_cnt + 16'd1;
        end
        RX_BITS:
        begin
          if (baud_cnt == baud_div - 16'd1)
          begin
            baud_cnt <= '0;
            shift_q <= shift_next;
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9)
            begin
              rx_valid <= 1'b1;
              rx_data <= shift_next[7:0];
              rx_parity_err <= (^shift_next[7:0]) ^ parity_odd ^ shift_next[8];
              rx_frame_err <= ~shift_next[9];
              state_q <= RX_IDLE;
            end
          end
          else
            baud_cnt <= baud_cnt + 16'd1;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/uart_cmd_fsm.sv
module uart_cmd_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::baud_div_t baud_div,
  input  uart_cmd_pkg::cmd_t      cmd,
  input  logic                    cmd_vld,
  input  logic                    tx_busy,
  input  logic                    tx_done,
  input  logic                    rx_valid,
  output logic                    cmd_rdy,
  output logic                    tx_start,
  output uart_cmd_pkg::byte_t     tx_data,
  output logic                    rx_enable
);

  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    GAP,
    SEND_LO,
    WAIT_REPLY
  } state_t;

  state_t                  state_q;
  uart_cmd_pkg::cmd_t      cmd_q;
  uart_cmd_pkg::baud_div_t baud_cnt;
  logic [2:0]              gap_cnt;
  logic                    sent_q;
  logic                    sending;

  assign sending = (state_q == SEND_HI) || (state_q == SEND_LO);

  // one start per send state, only once the serializer is free.
  assign tx_start = sending & ~sent_q & ~tx_busy;
  assign tx_data = (state_q == SEND_LO) ? cmd_q[7:0] : cmd_q[15:8];

  assign cmd_rdy = (state_q == IDLE);
  assign rx_enable = (state_q == WAIT_REPLY);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      cmd_q <= '0;
      baud_cnt <= '0;
      gap_cnt <= '0;
      sent_q <= 1'b0;
    end
    else
    begin
      if (tx_start)
        sent_q <= 1'b1;
      case (state_q)
        IDLE:
        begin
          if (cmd_vld)
          begin
            cmd_q <= cmd;
            sent_q <= 1'b0;
            state_q <= SEND_HI;
          end
        end
        SEND_HI:
        begin
          if (tx_done)
          begin
            sent_q <= 1'b0;
            baud_cnt <= '0;
            gap_cnt <= '0;
            // the high byte is the address frame in both cases.
            if (cmd_q[uart_cmd_pkg::CMD_WRITE_BIT])
              state_q <= GAP;
            else
              state_q <= WAIT_REPLY;
          end
        end
        GAP:
        begin
          if (baud_cnt == baud_div - 16'd1)
          begin
            baud_cnt <= '0;
            if (gap_cnt == 3'(uart_cmd_pkg::GAP_BITS - 1))
              state_q <= SEND_LO;
            else
              gap_cnt <= gap_cnt + 3'd1;
          end
          else
            baud_cnt <= baud_cnt + 16'd1;
        end
        SEND_LO:
        begin
          if (tx_done)
          begin
            sent_q <= 1'b0;
            state_q <= IDLE;
          end
        end
        WAIT_REPLY:
        begin
          // no timeout, a silent remote keeps us here.
          if (rx_valid)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  a_rx_tx_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(rx_enable && tx_busy));

endmodule

//--- rtl/uart_cmd_top.sv
module uart_cmd_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  uart_cmd_pkg::wb_adr_t  wb_adr,
  input  uart_cmd_pkg::wb_data_t wb_dat_w,
  output uart_cmd_pkg::wb_data_t wb_dat_r,
  output logic                   wb_ack,
  input  logic                   rx,
  output logic                   tx
);

  uart_cmd_pkg::baud_div_t baud_div;
  uart_cmd_pkg::cmd_t      cmd;
  uart_cmd_pkg::byte_t     tx_data;
  uart_cmd_pkg::byte_t     rx_data;
  logic                    parity_odd;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    tx_start;
  logic                    tx_busy;
  logic                    tx_done;
  logic                    rx_enable;
  logic                    rx_valid;
  logic                    rx_parity_err;
  logic                    rx_frame_err;

  uart_cfg_regs i_uart_cfg_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .cmd_rdy       (cmd_rdy),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err),
    .rx_data       (rx_data),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .baud_div      (baud_div),
    .parity_odd    (parity_odd),
    .cmd           (cmd),
    .cmd_vld       (cmd_vld)
  );

  uart_cmd_fsm i_uart_cmd_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .baud_div  (baud_div),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done),
    .rx_valid  (rx_valid),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .rx_enable (rx_enable)
  );

  uart_tx_frame i_uart_tx_frame (
    .clk        (clk),
    .rst_n      (rst_n),
    .baud_div   (baud_div),
    .parity_odd (parity_odd),
    .tx_start   (tx_start),
    .tx_data    (tx_data),
    .tx_busy    (tx_busy),
    .tx_done    (tx_done),
    .tx         (tx)
  );

  uart_rx_frame i_uart_rx_frame (
    .clk           (clk),
    .rst_n         (rst_n),
    .baud_div      (baud_div),
    .parity_odd    (parity_odd),
    .rx_enable     (rx_enable),
    .rx            (rx),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

//--- sim/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 2;
  localparam int RESET_CYCLES = 2;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release reset just after an edge.
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- sim/tb_uart_cmd_top.sv
module tb_uart_cmd_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BAUD = 8;
  localparam int CLK_NS = 4;
  localparam int NUM_CMDS = 10;
  localparam int WATCHDOG_NS = NUM_CMDS * 30 * BAUD * CLK_NS + 2000;
  localparam int ACK_LIMIT = 16;
  localparam int START_LIMIT = 40 * BAUD;
  localparam int IDLE_POLLS = 30 * BAUD;
  localparam uart_cmd_pkg::wb_data_t W1C_ALL = uart_cmd_pkg::wb_data_t'(
    (1 << uart_cmd_pkg::ST_RD_VALID) | (1 << uart_cmd_pkg::ST_PARITY_ERR) |
    (1 << uart_cmd_pkg::ST_FRAME_ERR) | (1 << uart_cmd_pkg::ST_CMD_DROP));

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  uart_cmd_pkg::wb_adr_t  wb_adr;
  uart_cmd_pkg::wb_data_t wb_dat_w;
  uart_cmd_pkg::wb_data_t wb_dat_r;
  logic                   wb_ack;
  logic                   rx;
  logic                   tx;

  integer                 seed;
  logic                   parity_odd_sel;
  logic [6:0]             last_wr_addr;
  uart_cmd_pkg::byte_t    last_rd_data;
  uart_cmd_pkg::byte_t    remote_mem [128];

  tb_clk_gen i_tb_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_top i_uart_cmd_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rx       (rx),
    .tx       (tx)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_data(input string name, input uart_cmd_pkg::wb_data_t expected,
                              input uart_cmd_pkg::wb_data_t actual);
    if (actual !== expected)
      report_fail($sformatf("FAILED %s: expected 0x%04h, actual 0x%04h", name, expected, actual));
  endtask

  task automatic compare_byte(input string name, input uart_cmd_pkg::byte_t expected,
                              input uart_cmd_pkg::byte_t actual);
    if (actual !== expected)
      report_fail($sformatf("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual));
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      report_fail($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
  endtask

  function automatic uart_cmd_pkg::wb_data_t status_word(input logic busy, input logic rd_valid,
                                                         input logic par_err, input logic frm_err,
                                                         input logic drop,
                                                         input uart_cmd_pkg::byte_t data);
    uart_cmd_pkg::wb_data_t w;
    w = '0;
    w[uart_cmd_pkg::ST_BUSY] = busy;
    w[uart_cmd_pkg::ST_RD_VALID] = rd_valid;
    w[uart_cmd_pkg::ST_PARITY_ERR] = par_err;
    w[uart_cmd_pkg::ST_FRAME_ERR] = frm_err;
    w[uart_cmd_pkg::ST_CMD_DROP] = drop;
    w[15:8] = data;
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone host
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // inputs change 1 ns after the rising edge.
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wb_access(input logic we, input uart_cmd_pkg::wb_adr_t adr,
                           input uart_cmd_pkg::wb_data_t wdata,
                           output uart_cmd_pkg::wb_data_t rdata);
    int waited;
    waited = 0;
    wait_cycles(1);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    do
    begin
      wait_cycles(1);
      waited++;
      if (waited > ACK_LIMIT)
        report_fail("wishbone access got no ack");
    end
    while (wb_ack !== 1'b1);
    rdata = wb_dat_r;
    // hold the cycle through the edge that samples ack.
    wait_cycles(1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_write(input uart_cmd_pkg::wb_adr_t adr, input uart_cmd_pkg::wb_data_t data);
    uart_cmd_pkg::wb_data_t unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input uart_cmd_pkg::wb_adr_t adr,
                         output uart_cmd_pkg::wb_data_t data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic set_parity(input logic odd);
    wb_write(uart_cmd_pkg::REG_CTRL, {15'd0, odd});
    parity_odd_sel = odd;
  endtask

  task automatic wait_idle(input string name, output uart_cmd_pkg::wb_data_t status);
    int polls;
    polls = 0;
    wb_read(uart_cmd_pkg::REG_STATUS, status);
    while (status[uart_cmd_pkg::ST_BUSY] !== 1'b0)
    begin
      polls++;
      if (polls > IDLE_POLLS)
        report_fail($sformatf("%s: bridge never left the busy state", name));
      wb_read(uart_cmd_pkg::REG_STATUS, status);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // remote device model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // idle returns the cycles waited for the start bit.
  task automatic get_frame(input string name, output uart_cmd_pkg::byte_t data,
                           output int idle);
    int i;
    idle = 0;
    while (tx !== 1'b0)
    begin
      wait_cycles(1);
      idle++;
      if (idle > START_LIMIT)
        report_fail($sformatf("%s: no start bit seen on tx", name));
    end
    wait_cycles(BAUD / 2);
    compare_bit({name, " start bit"}, 1'b0, tx);
    for (i = 0; i < 8; i++)
    begin
      wait_cycles(BAUD);
      data[i] = tx;
    end
    wait_cycles(BAUD);
    compare_bit({name, " parity bit"}, (^data) ^ parity_odd_sel, tx);
    wait_cycles(BAUD);
    compare_bit({name, " stop bit"}, 1'b1, tx);
  endtask

  task automatic send_frame(input uart_cmd_pkg::byte_t data, input logic bad_parity,
                            input logic bad_stop);
    logic [10:0] bits;
    int i;
    bits = {~bad_stop, (^data) ^ parity_odd_sel ^ bad_parity, data, 1'b0};
    for (i = 0; i < uart_cmd_pkg::FRAME_BITS; i++)
    begin
      rx = bits[i];
      wait_cycles(BAUD);
    end
    rx = 1'b1;
  endtask

  task automatic fill_remote_mem();
    int i;
    for (i = 0; i < 128; i++)
      remote_mem[i] = uart_cmd_pkg::byte_t'((i * 37) ^ 8'hc3);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command sequences
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_write_cmd(input string name, input uart_cmd_pkg::cmd_t cmd);
    uart_cmd_pkg::byte_t    hi;
    uart_cmd_pkg::byte_t    lo;
    uart_cmd_pkg::wb_data_t rd;
    int                     idle_hi;
    int                     idle_lo;
    int                     gap;
    fork
      wb_write(uart_cmd_pkg::REG_CMD, cmd);
      begin
        get_frame(name, hi, idle_hi);
        get_frame(name, lo, idle_lo);
      end
    join
    compare_byte({name, " high byte"}, cmd[15:8], hi);
    compare_byte({name, " low byte"}, cmd[7:0], lo);
    // idle_lo counts from the middle of the first stop bit.
    gap = idle_lo - (BAUD - BAUD / 2);
    if (gap < uart_cmd_pkg::GAP_BITS * BAUD)
      report_fail($sformatf("%s: tx idle only %0d cycles between frames", name, gap));
    // second stop bit is still on the line.
    wb_read(uart_cmd_pkg::REG_STATUS, rd);
    compare_bit({name, " busy"}, 1'b1, rd[uart_cmd_pkg::ST_BUSY]);
    wait_idle(name, rd);
    compare_data({name, " status"}, status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, last_rd_data), rd);
    wb_read(uart_cmd_pkg::REG_CMD, rd);
    compare_data({name, " cmd readback"}, cmd, rd);
    if (hi[7])
      remote_mem[hi[6:0]] = lo;
  endtask

  task automatic run_read_cmd(input string name, input logic [6:0] addr,
                              input logic bad_parity, input logic bad_stop);
    uart_cmd_pkg::cmd_t     cmd;
    uart_cmd_pkg::byte_t    hi;
    uart_cmd_pkg::byte_t    reply;
    uart_cmd_pkg::wb_data_t rd;
    int                     idle;
    cmd = {1'b0, addr, 8'($random(seed))};
    fork
      wb_write(uart_cmd_pkg::REG_CMD, cmd);
      get_frame(name, hi, idle);
    join
    compare_byte({name, " address frame"}, cmd[15:8], hi);
    reply = remote_mem[hi[6:0]];
    // one bit time of turnaround after the address frame.
    wait_cycles(BAUD);
    send_frame(reply, bad_parity, bad_stop);
    wait_idle(name, rd);
    last_rd_data = reply;
    compare_data({name, " status"},
                 status_word(1'b0, 1'b1, bad_parity, bad_stop, 1'b0, reply), rd);
    wb_write(uart_cmd_pkg::REG_STATUS, W1C_ALL);
    wb_read(uart_cmd_pkg::REG_STATUS, rd);
    compare_data({name, " status cleared"},
                 status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, reply), rd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset_values();
    uart_cmd_pkg::wb_data_t rd;
    wb_read(uart_cmd_pkg::REG_BAUD, rd);
    compare_data("reset BAUD", uart_cmd_pkg::BAUD_DIV_RESET, rd);
    wb_read(uart_cmd_pkg::REG_CTRL, rd);
    compare_data("reset CTRL", '0, rd);
    wb_read(uart_cmd_pkg::REG_STATUS, rd);
    compare_data("reset STATUS", '0, rd);
    compare_bit("reset tx", 1'b1, tx);
  endtask

  task automatic test_reg_readback();
    uart_cmd_pkg::wb_data_t val;
    uart_cmd_pkg::wb_data_t rd;
    val = uart_cmd_pkg::wb_data_t'($random(seed));
    wb_write(uart_cmd_pkg::REG_BAUD, val);
    wb_read(uart_cmd_pkg::REG_BAUD, rd);
    compare_data("BAUD readback", val, rd);
    val = uart_cmd_pkg::wb_data_t'($random(seed));
    wb_write(uart_cmd_pkg::REG_CTRL, val);
    wb_read(uart_cmd_pkg::REG_CTRL, rd);
    compare_data("CTRL readback", val, rd);
    wb_write(uart_cmd_pkg::REG_BAUD, uart_cmd_pkg::wb_data_t'(BAUD));
    wb_read(uart_cmd_pkg::REG_BAUD, rd);
    compare_data("BAUD test value", uart_cmd_pkg::wb_data_t'(BAUD), rd);
    set_parity(1'b0);
    wb_read(uart_cmd_pkg::REG_CTRL, rd);
    compare_data("CTRL cleared", '0, rd);
  endtask

  task automatic test_write_cmds();
    uart_cmd_pkg::cmd_t cmd;
    string              name;
    int                 p;
    int                 k;
    for (p = 0; p < 2; p++)
    begin
      set_parity(p[0]);
      if (p == 0)
        name = "write even parity";
      else
        name = "write odd parity";
      for (k = 0; k < 2; k++)
      begin
        cmd = {1'b1, 15'($random(seed))};
        last_wr_addr = cmd[14:8];
        run_write_cmd(name, cmd);
      end
    end
    set_parity(1'b0);
  endtask

  task automatic test_read_cmds();
    run_read_cmd("read even parity", last_wr_addr, 1'b0, 1'b0);
    set_parity(1'b1);
    run_read_cmd("read odd parity", 7'($random(seed)), 1'b0, 1'b0);
    set_parity(1'b0);
  endtask

  task automatic test_reply_errors();
    run_read_cmd("parity error reply", 7'($random(seed)), 1'b1, 1'b0);
    run_read_cmd("stop bit error reply", last_wr_addr, 1'b0, 1'b1);
  endtask

  task automatic test_cmd_drop();
    uart_cmd_pkg::cmd_t     first;
    uart_cmd_pkg::cmd_t     second;
    uart_cmd_pkg::byte_t    hi;
    uart_cmd_pkg::byte_t    lo;
    uart_cmd_pkg::wb_data_t rd;
    int                     idle_hi;
    int                     idle_lo;
    int                     i;
    first = {1'b1, 15'($random(seed))};
    second = {1'b1, 15'($random(seed))};
    fork
      begin
        wb_write(uart_cmd_pkg::REG_CMD, first);
        wb_write(uart_cmd_pkg::REG_CMD, second);
      end
      begin
        get_frame("cmd drop", hi, idle_hi);
        get_frame("cmd drop", lo, idle_lo);
      end
    join
    compare_byte("cmd drop high byte", first[15:8], hi);
    compare_byte("cmd drop low byte", first[7:0], lo);
    wait_idle("cmd drop", rd);
    compare_data("cmd drop status",
                 status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, last_rd_data), rd);
    // nothing of the dropped command may follow.
    for (i = 0; i < 2 * uart_cmd_pkg::FRAME_BITS * BAUD; i++)
    begin
      compare_bit("cmd drop quiet tx", 1'b1, tx);
      wait_cycles(1);
    end
    remote_mem[hi[6:0]] = lo;
    wb_write(uart_cmd_pkg::REG_STATUS,
             uart_cmd_pkg::wb_data_t'(1 << uart_cmd_pkg::ST_CMD_DROP));
    wb_read(uart_cmd_pkg::REG_STATUS, rd);
    compare_data("cmd drop cleared",
                 status_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, last_rd_data), rd);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    report_fail($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial
  begin
    seed = 59;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    rx = 1'b1;
    parity_odd_sel = 1'b0;
    last_wr_addr = '0;
    last_rd_data = '0;
    fill_remote_mem();
    @(posedge rst_n);
    wait_cycles(2);
    test_reset_values();
    test_reg_readback();
    test_write_cmds();
    test_read_cmds();
    test_reply_errors();
    test_cmd_drop();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- uart_cmd_top.f
rtl/uart_cmd_pkg.sv
rtl/uart_cfg_regs.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_fsm.sv
rtl/uart_cmd_top.sv
sim/tb_clk_gen.sv
sim/tb_uart_cmd_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_uart_cmd_top -f uart_cmd_top.f
out=$(./obj_dir/Vtb_uart_cmd_top 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
